//--- design/queue_pkg.sv
/* Word and FIFO sizing defaults for the two-class queue stage.
   Imported by the RTL and by the testbench model. */

`default_nettype none

package queue_pkg;

    // Default word width, class bit included
    parameter int WORD_W = 9;

    // Default log2 of the per-class FIFO depth
    parameter int ADDR_W = 3;

    // Class select sits in the top bit of the word
    parameter int CLASS_BIT = WORD_W - 1;

    // Words per class queue
    parameter int DEPTH = 1 << ADDR_W;

    typedef logic [WORD_W-1:0] word_t;

    // One extra bit so a full queue can be counted
    typedef logic [ADDR_W:0] count_t;

endpackage

`default_nettype wire

//--- design/arb_pkg.sv
/* Arbiter state and class-select encodings.
   Shared by the class FIFOs, the arbiter and the bound assertions. */

`default_nettype none

package arb_pkg;

    // Last class served by the output arbiter
    typedef enum logic [1:0] {
        ARB_IDLE    = 2'd0,
        ARB_LAST_C0 = 2'd1,
        ARB_LAST_C1 = 2'd2
    } arb_state_t;

    // Traffic class, same value as the class bit of a word
    typedef enum logic {
        CLASS_0 = 1'b0,
        CLASS_1 = 1'b1
    } class_sel_t;

endpackage

`default_nettype wire

//--- design/fifo_if.sv
/* Link between one class FIFO and the output arbiter.
   The FIFO presents its head word and status, the arbiter returns pop. */

`timescale 1ns/1ps
`default_nettype none

interface fifo_if #(
    parameter int word_w = queue_pkg::WORD_W,
    parameter int addr_w = queue_pkg::ADDR_W
);

    // Head word, registered at the pop edge
    logic [word_w-1:0] rd_data;
    logic              empty;
    logic              almost_full;
    logic [addr_w:0]   count;

    // One-cycle pop, only for a non-empty queue
    logic              pop;

    modport queue_side (
        output rd_data,
        output empty,
        output almost_full,
        output count,
        input  pop
    );

    modport arb_side (
        input  rd_data,
        input  empty,
        input  almost_full,
        input  count,
        output pop
    );

endinterface

`default_nettype wire

//--- design/fifo_mem.sv
/* Storage array for one class queue, written and read through separate pointers.
   Read data is registered and holds until the next read. */

`timescale 1ns/1ps
`default_nettype none

module fifo_mem #(
    parameter int word_w = queue_pkg::WORD_W,
    parameter int addr_w = queue_pkg::ADDR_W
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              wr_en,
    input  wire logic [addr_w-1:0] wr_ptr,
    input  wire logic [word_w-1:0] wr_data,
    input  wire logic              rd_en,
    input  wire logic [addr_w-1:0] rd_ptr,
    output logic      [word_w-1:0] rd_data
);

    logic [word_w-1:0] mem [1 << addr_w];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Head word lands here at the pop edge
    always_ff @(posedge clk) begin
        if (!reset) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

//--- design/class_fifo.sv
/* Queue for one traffic class, fed from the shared input strobe.
   Keeps pointers and occupancy, raises status flags and flags dropped words. */

`timescale 1ns/1ps
`default_nettype none

module class_fifo #(
    parameter int                  word_w      = queue_pkg::WORD_W,
    parameter int                  addr_w      = queue_pkg::ADDR_W,
    parameter arb_pkg::class_sel_t queue_class = arb_pkg::CLASS_0
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              in_valid,
    input  wire logic [word_w-1:0] in_data,
    input  wire logic [addr_w:0]   af_level,
    input  wire logic [addr_w:0]   ae_level,
    output logic                   full,
    output logic                   almost_empty,
    output logic                   error,
    fifo_if.queue_side             q
);

    logic [addr_w-1:0] wr_ptr;
    logic [addr_w-1:0] rd_ptr;
    logic [addr_w:0]   count;
    logic              class_hit;
    logic              push;
    logic              pop;

    // Word is ours when its top bit matches this queue
    assign class_hit = in_valid && (in_data[word_w-1] == queue_class);

    // Full is judged from the registered count, a pop in the same cycle does not help
    assign push  = class_hit && !full;
    assign error = class_hit && full;

    // Guard against a stray pop on an empty queue
    assign pop = q.pop && !q.empty;

    fifo_mem #(
        .word_w (word_w),
        .addr_w (addr_w)
    ) u_mem (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (push),
        .wr_ptr  (wr_ptr),
        .wr_data (in_data),
        .rd_en   (pop),
        .rd_ptr  (rd_ptr),
        .rd_data (q.rd_data)
    );

    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy, unchanged on push and pop together
    always_ff @(posedge clk) begin
        if (!reset) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Count never passes the depth, so the top bit alone means full
    assign full         = count[addr_w];
    assign q.empty      = (count == '0);
    assign almost_empty = (count <= ae_level) && (count != '0);
    assign q.almost_full = (count >= af_level);
    assign q.count      = count;

endmodule

`default_nettype wire

//--- design/class_arbiter.sv
/* Merges the two class queues onto one output strobe.
   Serves the non-empty queue, alternating when both hold words; out_hold stops pops. */

`timescale 1ns/1ps
`default_nettype none

module class_arbiter #(
    parameter int word_w = queue_pkg::WORD_W
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              out_hold,
    fifo_if.arb_side               q0,
    fifo_if.arb_side               q1,
    output logic                   out_valid,
    output logic      [word_w-1:0] out_data,
    output arb_pkg::class_sel_t    out_class,
    output logic                   pause
);

    import arb_pkg::*;

    arb_state_t state;
    logic       avail0;
    logic       avail1;
    logic       pop0;
    logic       pop1;

    assign avail0 = !q0.empty;
    assign avail1 = !q1.empty;

    // Idle counts as class 1 served last, so class 0 goes first
    always_comb begin
        pop0 = 1'b0;
        pop1 = 1'b0;
        if (!out_hold) begin
            if (avail0 && avail1) begin
                if (state == ARB_LAST_C0) begin
                    pop1 = 1'b1;
                end else begin
                    pop0 = 1'b1;
                end
            end else begin
                pop0 = avail0;
                pop1 = avail1;
            end
        end
    end

    assign q0.pop = pop0;
    assign q1.pop = pop1;

    // Strobe and tag line up with the memory read data one cycle after the pop
    always_ff @(posedge clk) begin
        if (!reset) begin
            out_valid <= 1'b0;
            out_class <= CLASS_0;
            state     <= ARB_IDLE;
        end else begin
            out_valid <= pop0 || pop1;
            if (pop0) begin
                out_class <= CLASS_0;
                state     <= ARB_LAST_C0;
            end else if (pop1) begin
                out_class <= CLASS_1;
                state     <= ARB_LAST_C1;
            end else if (!avail0 && !avail1) begin
                // Both queues drained, restart alternation
                state <= ARB_IDLE;
            end
        end
    end

    assign out_data = (out_class == CLASS_1) ? q1.rd_data : q0.rd_data;

    // Pause the source when either queue nears full
    assign pause = q0.almost_full || q1.almost_full;

endmodule

`default_nettype wire

//--- design/class_queue_top.sv
/* Two-class queue stage: input words are split by class into two FIFOs
   and merged again by an alternating arbiter onto one output strobe. */

`timescale 1ns/1ps
`default_nettype none

module class_queue_top #(
    parameter int word_w = queue_pkg::WORD_W,
    parameter int addr_w = queue_pkg::ADDR_W
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              in_valid,
    input  wire logic [word_w-1:0] in_data,
    input  wire logic [addr_w:0]   af_level,
    input  wire logic [addr_w:0]   ae_level,
    input  wire logic              out_hold,
    output logic                   out_valid,
    output logic      [word_w-1:0] out_data,
    output arb_pkg::class_sel_t    out_class,
    output logic                   full0,
    output logic                   full1,
    output logic                   empty0,
    output logic                   empty1,
    output logic                   almost_empty0,
    output logic                   almost_empty1,
    output logic                   error0,
    output logic                   error1,
    output logic                   pause
);

    import arb_pkg::*;

    fifo_if #(.word_w(word_w), .addr_w(addr_w)) q0_if ();
    fifo_if #(.word_w(word_w), .addr_w(addr_w)) q1_if ();

    class_fifo #(
        .word_w      (word_w),
        .addr_w      (addr_w),
        .queue_class (CLASS_0)
    ) u_fifo0 (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .af_level     (af_level),
        .ae_level     (ae_level),
        .full         (full0),
        .almost_empty (almost_empty0),
        .error        (error0),
        .q            (q0_if.queue_side)
    );

    class_fifo #(
        .word_w      (word_w),
        .addr_w      (addr_w),
        .queue_class (CLASS_1)
    ) u_fifo1 (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .af_level     (af_level),
        .ae_level     (ae_level),
        .full         (full1),
        .almost_empty (almost_empty1),
        .error        (error1),
        .q            (q1_if.queue_side)
    );

    class_arbiter #(
        .word_w (word_w)
    ) u_arb (
        .clk       (clk),
        .reset     (reset),
        .out_hold  (out_hold),
        .q0        (q0_if.arb_side),
        .q1        (q1_if.arb_side),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_class (out_class),
        .pause     (pause)
    );

    assign empty0 = q0_if.empty;
    assign empty1 = q1_if.empty;

endmodule

`default_nettype wire

//--- verif/class_queue_assertions.sv
/* Invariant checks bound into the class FIFOs and the arbiter.
   Ports a unit does not have are tied off at its bind. */

`timescale 1ns/1ps
`default_nettype none

module class_queue_assertions #(
    parameter int addr_w = queue_pkg::ADDR_W
) (
    input wire logic            clk,
    input wire logic            reset,
    input wire logic            pop,
    input wire logic            empty,
    input wire logic [addr_w:0] count,
    input wire logic            error,
    input wire logic            pop_any,
    input wire logic            out_valid
);

    localparam logic [addr_w:0] FULL_COUNT = (addr_w + 1)'(1 << addr_w);

    // Pop request from the arbiter against the queue's own empty flag
    a_pop_not_empty: assert property (@(posedge clk) disable iff (!reset)
        !(pop && empty))
        else $error("pop issued on an empty queue");

    a_count_limit: assert property (@(posedge clk) disable iff (!reset)
        count <= FULL_COUNT)
        else $error("occupancy above depth");

    a_valid_after_pop: assert property (@(posedge clk) disable iff (!reset)
        pop_any |=> out_valid)
        else $error("out_valid missing after pop");

    // Overflow only at full occupancy
    a_error_when_full: assert property (@(posedge clk) disable iff (!reset)
        error |-> (count == FULL_COUNT))
        else $error("overflow flagged on a queue that is not full");

    // Dropped word is never counted
    a_error_drops_word: assert property (@(posedge clk) disable iff (!reset)
        error |=> (count <= $past(count)))
        else $error("overflowing word was stored");

endmodule

bind class_fifo class_queue_assertions #(.addr_w(addr_w)) u_fifo_chk (
    .clk       (clk),
    .reset     (reset),
    .pop       (q.pop),
    .empty     (q.empty),
    .count     (count),
    .error     (error),
    .pop_any   (1'b0),
    .out_valid (1'b0)
);

bind class_arbiter class_queue_assertions u_arb_chk (
    .clk       (clk),
    .reset     (reset),
    .pop       (1'b0),
    .empty     (1'b0),
    .count     ('0),
    .error     (1'b0),
    .pop_any   (pop0 || pop1),
    .out_valid (out_valid)
);

`default_nettype wire

//--- verif/class_queue_tb.sv
/* Testbench for the two-class queue stage. Directed and random traffic from a fixed
   seed, checked every cycle against a model of both queues and the arbiter. */

`timescale 1ns/1ps
`default_nettype none

module class_queue_tb;

    import queue_pkg::*;
    import arb_pkg::*;

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 4;
    localparam int DIRECTED     = 80;
    localparam int PHASES       = 6;
    localparam int PHASE_LEN    = 250;
    localparam int TOTAL_CYCLES = RESET_CYCLES + DIRECTED + PHASES * PHASE_LEN;
    localparam int TIMEOUT_NS   = (TOTAL_CYCLES + 100) * PERIOD;

    logic       clk;
    logic       reset;
    logic       in_valid;
    word_t      in_data;
    count_t     af_level;
    count_t     ae_level;
    logic       out_hold;
    logic       out_valid;
    word_t      out_data;
    class_sel_t out_class;
    logic       full0;
    logic       full1;
    logic       empty0;
    logic       empty1;
    logic       almost_empty0;
    logic       almost_empty1;
    logic       error0;
    logic       error1;
    logic       pause;

    // Reference model state
    word_t      model_q0[$];
    word_t      model_q1[$];
    arb_state_t last_served;
    logic       exp_valid;
    logic       exp_class;
    word_t      exp_data;
    count_t     af_next;
    count_t     ae_next;
    logic [31:0] rng;
    int         burst_left;
    logic       hold_now;

    class_queue_top dut (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .af_level      (af_level),
        .ae_level      (ae_level),
        .out_hold      (out_hold),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_class     (out_class),
        .full0         (full0),
        .full1         (full1),
        .empty0        (empty0),
        .empty1        (empty1),
        .almost_empty0 (almost_empty0),
        .almost_empty1 (almost_empty1),
        .error0        (error0),
        .error1        (error1),
        .pause         (pause)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: stimulus did not complete within %0d ns", TIMEOUT_NS);
        $display("Simulation FAILED");
        $fatal(1, "Watchdog expired");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Status flags of one class against the model occupancy n
    task automatic check_flags(input string tag, input int n, input logic cls,
                               input logic full_v, input logic empty_v,
                               input logic ae_v, input logic err_v);
        logic hit;
        hit = in_valid && (in_data[CLASS_BIT] == cls);
        check_value({"full", tag}, 32'(full_v), 32'(n == DEPTH));
        check_value({"empty", tag}, 32'(empty_v), 32'(n == 0));
        check_value({"almost_empty", tag}, 32'(ae_v),
                    32'((n != 0) && (n <= int'(ae_level))));
        check_value({"error", tag}, 32'(err_v), 32'(hit && (n == DEPTH)));
    endtask

    task automatic check_outputs();
        int n0;
        int n1;
        n0 = model_q0.size();
        n1 = model_q1.size();
        check_value("out_valid", 32'(out_valid), 32'(exp_valid));
        if (exp_valid) begin
            check_value("out_class", 32'(out_class), 32'(exp_class));
            check_value("out_data", 32'(out_data), 32'(exp_data));
        end
        check_flags("0", n0, 1'b0, full0, empty0, almost_empty0, error0);
        check_flags("1", n1, 1'b1, full1, empty1, almost_empty1, error1);
        check_value("pause", 32'(pause),
                    32'((n0 >= int'(af_level)) || (n1 >= int'(af_level))));
    endtask

    // Advance the model across the coming rising edge
    task automatic model_step();
        int   n0;
        int   n1;
        logic pop0;
        logic pop1;
        n0 = model_q0.size();
        n1 = model_q1.size();
        pop0 = 1'b0;
        pop1 = 1'b0;
        if (!out_hold) begin
            if (n0 != 0 && n1 != 0) begin
                pop1 = (last_served == ARB_LAST_C0);
                pop0 = !pop1;
            end else begin
                pop0 = (n0 != 0);
                pop1 = (n1 != 0);
            end
        end
        exp_valid = pop0 || pop1;
        if (pop0) begin
            exp_data    = model_q0.pop_front();
            exp_class   = 1'b0;
            last_served = ARB_LAST_C0;
        end else if (pop1) begin
            exp_data    = model_q1.pop_front();
            exp_class   = 1'b1;
            last_served = ARB_LAST_C1;
        end else if (n0 == 0 && n1 == 0) begin
            last_served = ARB_IDLE;
        end
        // Acceptance uses the occupancy at the start of the cycle
        if (in_valid && !in_data[CLASS_BIT] && n0 < DEPTH) begin
            model_q0.push_back(in_data);
        end
        if (in_valid && in_data[CLASS_BIT] && n1 < DEPTH) begin
            model_q1.push_back(in_data);
        end
    endtask

    task automatic run_cycle(input logic v, input word_t d, input logic hold);
        @(negedge clk);
        in_valid = v;
        in_data  = d;
        out_hold = hold;
        af_level = af_next;
        ae_level = ae_next;
        #1;
        check_outputs();
        model_step();
    endtask

    initial begin
        reset       = 1'b0;
        in_valid    = 1'b0;
        in_data     = '0;
        out_hold    = 1'b0;
        af_next     = count_t'(DEPTH - 2);
        ae_next     = count_t'(2);
        af_level    = af_next;
        ae_level    = ae_next;
        last_served = ARB_IDLE;
        exp_valid   = 1'b0;
        exp_class   = 1'b0;
        exp_data    = '0;
        rng         = 32'h9bfe_937e;
        burst_left  = 0;
        hold_now    = 1'b0;

        repeat (RESET_CYCLES) @(negedge clk);
        #1;
        check_outputs();
        reset = 1'b1;

        // Single words into an idle system, one per class
        run_cycle(1'b1, word_t'(9'h1a5), 1'b0);
        repeat (4) run_cycle(1'b0, '0, 1'b0);
        run_cycle(1'b1, word_t'(9'h03c), 1'b0);
        repeat (4) run_cycle(1'b0, '0, 1'b0);

        // Both classes backed up, then released to alternate
        for (int i = 0; i < 6; i++) begin
            run_cycle(1'b1, word_t'({i[0], 8'(i + 8'h40)}), 1'b1);
        end
        repeat (10) run_cycle(1'b0, '0, 1'b0);

        // Overflow class 0 while held, then drain
        for (int i = 0; i < DEPTH + 3; i++) begin
            run_cycle(1'b1, word_t'({1'b0, 8'(i + 8'h80)}), 1'b1);
        end
        run_cycle(1'b1, word_t'(9'h1f0), 1'b1);
        repeat (20) run_cycle(1'b0, '0, 1'b0);

        for (int p = 0; p < PHASES; p++) begin
            rng = xorshift32(rng);
            af_next = count_t'(rng % 32'(DEPTH + 1));
            rng = xorshift32(rng);
            ae_next = count_t'(rng % 32'(DEPTH));
            for (int i = 0; i < PHASE_LEN; i++) begin
                if (burst_left == 0) begin
                    rng = xorshift32(rng);
                    hold_now   = (rng[3:0] < 4'd5);
                    burst_left = int'(rng[9:6]) + 1;
                end
                burst_left--;
                rng = xorshift32(rng);
                run_cycle((rng % 32'd10) < 32'd7, rng[WORD_W+15:16], hold_now);
            end
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- class_queue_top.f
design/queue_pkg.sv
design/arb_pkg.sv
design/fifo_if.sv
design/fifo_mem.sv
design/class_fifo.sv
design/class_arbiter.sv
design/class_queue_top.sv
verif/class_queue_assertions.sv
verif/class_queue_tb.sv

//--- Makefile
# Verilator build and run for the two-class queue stage

VERILATOR  ?= verilator
TOP        := class_queue_tb
FILELIST   := class_queue_top.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
PASS_MSG   := Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
